//--- tb.f
+incdir+design
+incdir+dv
design/mipsInstrPkg.sv
design/mipsMemPkg.sv
design/memAccessIntf.sv
design/memOpDecode.sv
design/memAccessExec.sv
design/memResult.sv
design/memStage.sv
dv/memStageTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module memStageTb -Mdir obj_dir -o memStageSim

# simulator output goes to the log
./obj_dir/memStageSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- dv/memStageVectors.svh
`ifndef MEM_STAGE_VECTORS_SVH
`define MEM_STAGE_VECTORS_SVH

// one table row, outputs are expected one cycle after the row is driven
typedef struct packed {
    logic       valid;
    memOp_t     op;
    word_t      addr;
    word_t      wdata;
    logic [5:0] extInt;
    logic [1:0] swIp;
    intVec_t    intMask;
    word_t      expRdata;
    excCode_t   expExc;
    word_t      expBad;
    logic       expEret;
    intVec_t    expInt;
} vecRow_t;

vecRow_t vecTable[$];
string   rowNames[$];

// memory or trap row, interrupt inputs held at zero
task automatic addMemRow(string name, memOp_t op, word_t addr, word_t wdata,
                         word_t expRdata, excCode_t expExc, word_t expBad);
    vecRow_t r;
    r          = '0;
    r.valid    = 1'b1;
    r.op       = op;
    r.addr     = addr;
    r.wdata    = wdata;
    r.expRdata = expRdata;
    r.expExc   = expExc;
    r.expBad   = expBad;
    r.expEret  = (op == ERET);
    vecTable.push_back(r);
    rowNames.push_back(name);
endtask

// NOP row that only exercises the interrupt vector
task automatic addIntRow(string name, logic [5:0] ext, logic [1:0] sw, intVec_t mask,
                         intVec_t expInt);
    vecRow_t r;
    r         = '0;
    r.valid   = 1'b1;
    r.op      = NOP;
    r.extInt  = ext;
    r.swIp    = sw;
    r.intMask = mask;
    r.expInt  = expInt;
    vecTable.push_back(r);
    rowNames.push_back(name);
endtask

task automatic fillTable();
    addMemRow("sw_word",   SW,  32'h10, 32'hDEADBEEF, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("lw_word",   LW,  32'h10, 32'h0,        32'hDEADBEEF, `EXC_NONE, 32'h0);
    // byte lanes of word 0x20
    addMemRow("sw_init20", SW,  32'h20, 32'h11223344, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("sb_off0",   SB,  32'h20, 32'h000000A5, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("sb_off1",   SB,  32'h21, 32'h0000007E, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("sb_off2",   SB,  32'h22, 32'hFFFFFF80, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("sb_off3",   SB,  32'h23, 32'h12345601, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("lb_off0",   LB,  32'h20, 32'h0,        32'hFFFFFFA5, `EXC_NONE, 32'h0);
    addMemRow("lbu_off0",  LBU, 32'h20, 32'h0,        32'h000000A5, `EXC_NONE, 32'h0);
    addMemRow("lb_off1",   LB,  32'h21, 32'h0,        32'h0000007E, `EXC_NONE, 32'h0);
    addMemRow("lb_off2",   LB,  32'h22, 32'h0,        32'hFFFFFF80, `EXC_NONE, 32'h0);
    addMemRow("lbu_off2",  LBU, 32'h22, 32'h0,        32'h00000080, `EXC_NONE, 32'h0);
    addMemRow("lb_off3",   LB,  32'h23, 32'h0,        32'h00000001, `EXC_NONE, 32'h0);
    addMemRow("lw_bytes",  LW,  32'h20, 32'h0,        32'h01807EA5, `EXC_NONE, 32'h0);
    // halfword lanes of word 0x24
    addMemRow("sh_off0",   SH,  32'h24, 32'h0000F00D, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("sh_off2",   SH,  32'h26, 32'hFFFF8765, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("lh_off0",   LH,  32'h24, 32'h0,        32'hFFFFF00D, `EXC_NONE, 32'h0);
    addMemRow("lhu_off0",  LHU, 32'h24, 32'h0,        32'h0000F00D, `EXC_NONE, 32'h0);
    addMemRow("lh_off2",   LH,  32'h26, 32'h0,        32'hFFFF8765, `EXC_NONE, 32'h0);
    addMemRow("lhu_off2",  LHU, 32'h26, 32'h0,        32'h00008765, `EXC_NONE, 32'h0);
    addMemRow("lw_halves", LW,  32'h24, 32'h0,        32'h8765F00D, `EXC_NONE, 32'h0);
    // misaligned accesses around word 0x30
    addMemRow("sw_init30", SW,  32'h30, 32'h0BADC0DE, 32'h0,        `EXC_NONE, 32'h0);
    addMemRow("lw_mis",    LW,  32'h31, 32'h0,        32'h0,        `EXC_ADEL, 32'h31);
    addMemRow("lh_mis",    LH,  32'h33, 32'h0,        32'h0,        `EXC_ADEL, 32'h33);
    addMemRow("sh_mis",    SH,  32'h31, 32'hFFFFFFFF, 32'h0,        `EXC_ADES, 32'h31);
    addMemRow("sw_mis",    SW,  32'h32, 32'hFFFFFFFF, 32'h0,        `EXC_ADES, 32'h32);
    addMemRow("lw_kept",   LW,  32'h30, 32'h0,        32'h0BADC0DE, `EXC_NONE, 32'h0);
    addMemRow("lhu_hi30",  LHU, 32'h32, 32'h0,        32'h00000BAD, `EXC_NONE, 32'h0);
    addMemRow("lb_top30",  LB,  32'h33, 32'h0,        32'h0000000B, `EXC_NONE, 32'h0);
    // traps and return, odd addresses must not matter here
    addMemRow("syscall",   SYSCALL, 32'h44, 32'h0,    32'h0,        `EXC_SYS,  32'h0);
    addMemRow("break",     BREAK,   32'h47, 32'h0,    32'h0,        `EXC_BP,   32'h0);
    addMemRow("eret",      ERET,    32'h0,  32'h0,    32'h0,        `EXC_NONE, 32'h0);
    addMemRow("nop",       NOP,     32'h0,  32'h0,    32'h0,        `EXC_NONE, 32'h0);
    // interrupt vector: ext in 7..2, sw in 1..0, then mask
    addIntRow("int_all",  6'h3F, 2'b11, 8'hFF, 8'hFF);
    addIntRow("int_ext0", 6'h01, 2'b00, 8'hFF, 8'h04);
    addIntRow("int_mix",  6'h20, 2'b10, 8'hFF, 8'h82);
    addIntRow("int_low",  6'h2A, 2'b01, 8'h0F, 8'h09);
    addIntRow("int_off",  6'h3F, 2'b11, 8'h00, 8'h00);
    addIntRow("int_high", 6'h15, 2'b10, 8'hF0, 8'h50);
endtask

`endif

//--- dv/memStageTb.sv
`include "mips_params.svh"

module memStageTb
    import mipsInstrPkg::*;
    import mipsMemPkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int RANDOM_COUNT = 64;
    localparam int RANDOM_WORDS = 8;
    localparam int RANDOM_BASE  = 'h100;

    logic       clk;
    logic       rstN;
    logic       inValid;
    memOp_t     inOp;
    word_t      inAddr;
    word_t      inWdata;
    regAddr_t   inDestReg;
    logic [5:0] extInt;
    logic [1:0] swIp;
    intVec_t    intMask;
    logic       outValid;
    memOp_t     outOp;
    word_t      outRdata;
    word_t      outAddr;
    regAddr_t   outDestReg;
    logic       excValid;
    excCode_t   excCode;
    word_t      badVaddr;
    logic       eretPulse;
    intVec_t    intPending;

    logic tableReady = 1'b0;

    `include "memStageVectors.svh"

    memStage memStage_inst (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inOp       (inOp),
        .inAddr     (inAddr),
        .inWdata    (inWdata),
        .inDestReg  (inDestReg),
        .extInt     (extInt),
        .swIp       (swIp),
        .intMask    (intMask),
        .outValid   (outValid),
        .outOp      (outOp),
        .outRdata   (outRdata),
        .outAddr    (outAddr),
        .outDestReg (outDestReg),
        .excValid   (excValid),
        .excCode    (excCode),
        .badVaddr   (badVaddr),
        .eretPulse  (eretPulse),
        .intPending (intPending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run length follows the table size and the random count
    initial begin
        wait (tableReady);
        #((vecTable.size() + RANDOM_COUNT + 20) * CLK_PERIOD);
        $display("timeout: the DUT did not get through all tests in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    task automatic checkValue(string testName, string field, logic [31:0] expected,
                              logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected 0x%08h actual 0x%08h",
                     testName, field, expected, actual);
            $display("Something failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic driveIdle();
        inValid   = 1'b0;
        inOp      = NOP;
        inAddr    = '0;
        inWdata   = '0;
        inDestReg = '0;
        extInt    = '0;
        swIp      = '0;
        intMask   = '0;
    endtask

    task automatic applyRow(vecRow_t r, int idx);
        inValid   = r.valid;
        inOp      = r.op;
        inAddr    = r.addr;
        inWdata   = r.wdata;
        inDestReg = regAddr_t'(idx);
        extInt    = r.extInt;
        swIp      = r.swIp;
        intMask   = r.intMask;
    endtask

    task automatic checkRow(int idx);
        vecRow_t r;
        string   name;
        r    = vecTable[idx];
        name = rowNames[idx];
        checkValue(name, "outValid", 32'(r.valid), 32'(outValid));
        checkValue(name, "outOp", 32'(r.op), 32'(outOp));
        checkValue(name, "outAddr", r.addr, outAddr);
        checkValue(name, "outDestReg", 32'(idx % 32), 32'(outDestReg));
        checkValue(name, "outRdata", r.expRdata, outRdata);
        checkValue(name, "excValid", 32'(r.expExc != `EXC_NONE), 32'(excValid));
        checkValue(name, "excCode", 32'(r.expExc), 32'(excCode));
        checkValue(name, "badVaddr", r.expBad, badVaddr);
        checkValue(name, "eretPulse", 32'(r.expEret), 32'(eretPulse));
    endtask

    // row i goes in while the result of row i-1 is on the outputs
    task automatic runTable();
        int n;
        n = vecTable.size();
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            #1;
            if (i < n) begin
                applyRow(vecTable[i], i);
            end else begin
                driveIdle();
            end
            #1;
            if (i < n) begin
                checkValue(rowNames[i], "intPending", 32'(vecTable[i].expInt),
                           32'(intPending));
            end
            if (i > 0) begin
                checkRow(i - 1);
            end
        end
    endtask

    // reference RAM update by the store lane rules
    function automatic word_t mergeStore(memOp_t op, word_t oldWord, logic [1:0] offset,
                                         word_t wdata);
        word_t w;
        w = oldWord;
        case (op)
            SW: w = wdata;
            SH: w[16 * offset[1] +: 16] = wdata[15:0];
            SB: w[8 * offset +: 8] = wdata[7:0];
            default: w = oldWord;
        endcase
        return w;
    endfunction

    // expected load result by the extension rules
    // non-loads give zero
    function automatic word_t expectLoad(memOp_t op, word_t w, logic [1:0] offset);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       res;
        b = w[8 * offset +: 8];
        h = offset[1] ? w[31:16] : w[15:0];
        case (op)
            LW:      res = w;
            LB:      res = {{24{b[7]}}, b};
            LBU:     res = {24'h0, b};
            LH:      res = {{16{h[15]}}, h};
            LHU:     res = {16'h0, h};
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic runRandom();
        word_t    model [RANDOM_WORDS];
        memOp_t   op;
        memOp_t   prevOp;
        word_t    addr;
        word_t    wdata;
        word_t    expRdata;
        word_t    prevAddr;
        word_t    prevRdata;
        regAddr_t prevDest;
        int       wordIdx;
        int       offset;
        int       opSel;
        logic     havePrev;
        string    name;
        havePrev = 1'b0;
        for (int n = 0; n <= RANDOM_COUNT; n++) begin
            @(posedge clk);
            #1;
            if (n < RANDOM_COUNT) begin
                // the first stores give every word of the window a known value
                if (n < RANDOM_WORDS) begin
                    op      = SW;
                    wordIdx = n;
                end else begin
                    opSel   = $urandom_range(7, 0);
                    wordIdx = $urandom_range(RANDOM_WORDS - 1, 0);
                    case (opSel)
                        0:       op = SW;
                        1:       op = SH;
                        2:       op = SB;
                        3:       op = LW;
                        4:       op = LH;
                        5:       op = LHU;
                        6:       op = LB;
                        default: op = LBU;
                    endcase
                end
                case (op)
                    SB, LB, LBU: offset = $urandom_range(3, 0);
                    SH, LH, LHU: offset = 2 * $urandom_range(1, 0);
                    default:     offset = 0;
                endcase
                addr     = word_t'(RANDOM_BASE + 4 * wordIdx + offset);
                wdata    = $urandom();
                expRdata = expectLoad(op, model[wordIdx], offset[1:0]);
                model[wordIdx] = mergeStore(op, model[wordIdx], offset[1:0], wdata);
                inValid   = 1'b1;
                inOp      = op;
                inAddr    = addr;
                inWdata   = wdata;
                inDestReg = regAddr_t'(n);
            end else begin
                driveIdle();
            end
            #1;
            if (havePrev) begin
                name = $sformatf("random_%0d", n - 1);
                checkValue(name, "outValid", 32'h1, 32'(outValid));
                checkValue(name, "outOp", 32'(prevOp), 32'(outOp));
                checkValue(name, "outAddr", prevAddr, outAddr);
                checkValue(name, "outDestReg", 32'(prevDest), 32'(outDestReg));
                checkValue(name, "outRdata", prevRdata, outRdata);
                checkValue(name, "excValid", 32'h0, 32'(excValid));
            end
            havePrev  = (n < RANDOM_COUNT);
            prevOp    = op;
            prevAddr  = addr;
            prevRdata = expRdata;
            prevDest  = regAddr_t'(n);
        end
    endtask

    initial begin
        void'($urandom(85184));
        rstN = 1'b0;
        driveIdle();
        fillTable();
        tableReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        #1;
        checkValue("reset", "outValid", 32'h0, 32'(outValid));
        checkValue("reset", "excValid", 32'h0, 32'(excValid));
        checkValue("reset", "eretPulse", 32'h0, 32'(eretPulse));
        runTable();
        runRandom();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- design/memStage.sv
module memStage
    import mipsInstrPkg::*;
    import mipsMemPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       inValid,
    input  memOp_t     inOp,
    input  word_t      inAddr,
    input  word_t      inWdata,
    input  regAddr_t   inDestReg,
    input  logic [5:0] extInt,
    input  logic [1:0] swIp,
    input  intVec_t    intMask,
    output logic       outValid,
    output memOp_t     outOp,
    output word_t      outRdata,
    output word_t      outAddr,
    output regAddr_t   outDestReg,
    output logic       excValid,
    output excCode_t   excCode,
    output word_t      badVaddr,
    output logic       eretPulse,
    output intVec_t    intPending
);

    // registered access between execute and result
    logic       rValid;
    memOp_t     rOp;
    word_t      rAddr;
    regAddr_t   rDestReg;
    accSize_t   rSize;
    logic       rSignExt;
    logic [1:0] rOffset;
    word_t      rRamWord;
    excCode_t   rExcCode;

    memAccessIntf acc ();

    memOpDecode memOpDecode_inst (
        .inValid    (inValid),
        .inOp       (inOp),
        .inAddr     (inAddr),
        .inWdata    (inWdata),
        .inDestReg  (inDestReg),
        .extInt     (extInt),
        .swIp       (swIp),
        .intMask    (intMask),
        .intPending (intPending),
        .acc        (acc.decode)
    );

    memAccessExec memAccessExec_inst (
        .clk      (clk),
        .rstN     (rstN),
        .acc      (acc.exec),
        .rValid   (rValid),
        .rOp      (rOp),
        .rAddr    (rAddr),
        .rDestReg (rDestReg),
        .rSize    (rSize),
        .rSignExt (rSignExt),
        .rOffset  (rOffset),
        .rRamWord (rRamWord),
        .rExcCode (rExcCode)
    );

    memResult memResult_inst (
        .rValid     (rValid),
        .rOp        (rOp),
        .rAddr      (rAddr),
        .rDestReg   (rDestReg),
        .rSize      (rSize),
        .rSignExt   (rSignExt),
        .rOffset    (rOffset),
        .rRamWord   (rRamWord),
        .rExcCode   (rExcCode),
        .outValid   (outValid),
        .outOp      (outOp),
        .outRdata   (outRdata),
        .outAddr    (outAddr),
        .outDestReg (outDestReg),
        .excValid   (excValid),
        .excCode    (excCode),
        .badVaddr   (badVaddr),
        .eretPulse  (eretPulse)
    );

endmodule

//--- design/memResult.sv
`include "mips_params.svh"

module memResult
    import mipsInstrPkg::*;
    import mipsMemPkg::*;
(
    input  logic     rValid,
    input  memOp_t   rOp,
    input  word_t    rAddr,
    input  regAddr_t rDestReg,
    input  accSize_t rSize,
    input  logic     rSignExt,
    input  logic [1:0] rOffset,
    input  word_t    rRamWord,
    input  excCode_t rExcCode,
    output logic     outValid,
    output memOp_t   outOp,
    output word_t    outRdata,
    output word_t    outAddr,
    output regAddr_t outDestReg,
    output logic     excValid,
    output excCode_t excCode,
    output word_t    badVaddr,
    output logic     eretPulse
);

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    word_t       loadData;
    logic        isLoad;
    logic        addrErr;

    // lane picked by the low address bits
    assign laneByte = rRamWord[8*rOffset +: 8];
    assign laneHalf = rOffset[1] ? rRamWord[31:16] : rRamWord[15:0];

    always_comb begin
        case (rSize)
            BYTE: begin
                loadData = {{24{rSignExt & laneByte[7]}}, laneByte};
            end
            HALF: begin
                loadData = {{16{rSignExt & laneHalf[15]}}, laneHalf};
            end
            default: begin
                loadData = rRamWord;
            end
        endcase
    end

    assign isLoad = (rOp == LW) || (rOp == LH) || (rOp == LHU) ||
                    (rOp == LB) || (rOp == LBU);

    assign excValid = rValid && (rExcCode != `EXC_NONE);
    assign addrErr  = (rExcCode == `EXC_ADEL) || (rExcCode == `EXC_ADES);

    // faulted loads never read the RAM, so they return zero
    assign outRdata = (rValid && isLoad && !excValid) ? loadData : '0;

    assign outValid   = rValid;
    assign outOp      = rOp;
    assign outAddr    = rAddr;
    assign outDestReg = rDestReg;
    assign excCode    = excValid ? rExcCode : `EXC_NONE;
    assign badVaddr   = (excValid && addrErr) ? rAddr : '0;
    assign eretPulse  = rValid && (rOp == ERET);

endmodule

//--- design/memAccessExec.sv
`include "mips_params.svh"

module memAccessExec
    import mipsInstrPkg::*;
    import mipsMemPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    memAccessIntf.exec acc,
    output logic     rValid,
    output memOp_t   rOp,
    output word_t    rAddr,
    output regAddr_t rDestReg,
    output accSize_t rSize,
    output logic     rSignExt,
    output logic [1:0] rOffset,
    output word_t    rRamWord,
    output excCode_t rExcCode
);

    localparam int RAM_DEPTH = 1 << `RAM_ADDR_W;

    word_t ram [RAM_DEPTH];

    logic [`RAM_ADDR_W-1:0] ramIdx;
    byteEn_t byteEn;
    word_t   storeData;
    logic    writeEn;
    logic    readEn;

    // word index, byte offset dropped
    assign ramIdx = acc.addr[`RAM_ADDR_W+1:2];

    // lane mask and replicated data
    always_comb begin
        byteEn    = 4'b0000;
        storeData = acc.wdata;
        case (acc.size)
            BYTE: begin
                byteEn    = 4'b0001 << acc.addr[1:0];
                storeData = {4{acc.wdata[7:0]}};
            end
            HALF: begin
                byteEn    = acc.addr[1] ? 4'b1100 : 4'b0011;
                storeData = {2{acc.wdata[15:0]}};
            end
            WORD: begin
                byteEn = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    assign writeEn = acc.valid && acc.isStore && !acc.fault;
    assign readEn  = acc.valid && acc.isLoad && !acc.fault;

    // byte-lane write, synchronous read
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (writeEn && byteEn[i]) begin
                ram[ramIdx][8*i +: 8] <= storeData[8*i +: 8];
            end
        end
        if (readEn) begin
            rRamWord <= ram[ramIdx];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rValid <= 1'b0;
        end else begin
            rValid <= acc.valid;
        end
    end

    // access description for the result step
    always_ff @(posedge clk) begin
        if (acc.valid) begin
            rOp      <= acc.op;
            rAddr    <= acc.addr;
            rDestReg <= acc.destReg;
            rSize    <= acc.size;
            rSignExt <= acc.signExt;
            rOffset  <= acc.addr[1:0];
            rExcCode <= acc.excCode;
        end
    end

endmodule

//--- design/memOpDecode.sv
`include "mips_params.svh"

module memOpDecode
    import mipsInstrPkg::*;
    import mipsMemPkg::*;
(
    input  logic      inValid,
    input  memOp_t    inOp,
    input  word_t     inAddr,
    input  word_t     inWdata,
    input  regAddr_t  inDestReg,
    input  logic [5:0] extInt,
    input  logic [1:0] swIp,
    input  intVec_t   intMask,
    output intVec_t   intPending,
    memAccessIntf.decode acc
);

    accSize_t size;
    logic     signExt;
    logic     isLoad;
    logic     isStore;
    logic     misaligned;
    excCode_t excCode;

    // size and class per operation
    always_comb begin
        size    = WORD;
        signExt = 1'b0;
        isLoad  = 1'b0;
        isStore = 1'b0;
        case (inOp)
            LW: begin
                isLoad = 1'b1;
            end
            LH: begin
                size    = HALF;
                signExt = 1'b1;
                isLoad  = 1'b1;
            end
            LHU: begin
                size   = HALF;
                isLoad = 1'b1;
            end
            LB: begin
                size    = BYTE;
                signExt = 1'b1;
                isLoad  = 1'b1;
            end
            LBU: begin
                size   = BYTE;
                isLoad = 1'b1;
            end
            SW: begin
                isStore = 1'b1;
            end
            SH: begin
                size    = HALF;
                isStore = 1'b1;
            end
            SB: begin
                size    = BYTE;
                isStore = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // byte accesses never fault
    assign misaligned = ((size == WORD) && (inAddr[1:0] != 2'b00)) ||
                        ((size == HALF) && inAddr[0]);

    // address errors take priority, only one can apply anyway
    always_comb begin
        if (isLoad && misaligned) begin
            excCode = `EXC_ADEL;
        end else if (isStore && misaligned) begin
            excCode = `EXC_ADES;
        end else if (inOp == SYSCALL) begin
            excCode = `EXC_SYS;
        end else if (inOp == BREAK) begin
            excCode = `EXC_BP;
        end else begin
            excCode = `EXC_NONE;
        end
    end

    assign acc.valid   = inValid;
    assign acc.op      = inOp;
    assign acc.addr    = inAddr;
    assign acc.wdata   = inWdata;
    assign acc.destReg = inDestReg;
    assign acc.size    = size;
    assign acc.signExt = signExt;
    assign acc.isLoad  = isLoad;
    assign acc.isStore = isStore;
    assign acc.fault   = (isLoad || isStore) && misaligned;
    assign acc.excCode = excCode;

    // IP[7:2] external, IP[1:0] software, then status mask
    assign intPending = ({extInt, 2'b00} | intVec_t'(swIp)) & intMask;

endmodule

//--- design/memAccessIntf.sv
interface memAccessIntf import mipsInstrPkg::*, mipsMemPkg::*; ();

    logic     valid;
    memOp_t   op;
    word_t    addr;
    word_t    wdata;
    regAddr_t destReg;
    accSize_t size;
    logic     signExt;
    logic     isLoad;
    logic     isStore;
    // misaligned access, RAM must not be touched
    logic     fault;
    excCode_t excCode;

    modport decode (
        output valid, op, addr, wdata, destReg, size, signExt,
        output isLoad, isStore, fault, excCode
    );

    modport exec (
        input valid, op, addr, wdata, destReg, size, signExt,
        input isLoad, isStore, fault, excCode
    );

endinterface

//--- design/mipsMemPkg.sv
package mipsMemPkg;

    // one enable per byte lane
    typedef logic [3:0] byteEn_t;

    // access width
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } accSize_t;

    // cause register exception code
    typedef logic [4:0] excCode_t;

    // interrupt lines, 6 external plus 2 software
    typedef logic [7:0] intVec_t;

    // destination register, carried along with the data
    typedef logic [4:0] regAddr_t;

endpackage

//--- design/mipsInstrPkg.sv
`include "mips_params.svh"

package mipsInstrPkg;

    // one data word
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // operations seen by the memory stage
    // ALU-type instructions arrive here as NOP
    typedef enum logic [3:0] {
        NOP,
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB,
        SYSCALL,
        BREAK,
        ERET
    } memOp_t;

endpackage

//--- design/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath word
`define DATA_WIDTH 32

// data RAM word address, 256 words
`define RAM_ADDR_W 8

// exception codes as in the CP0 cause register
`define EXC_NONE 5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9

`endif
